/* ll_config_pkg.sv */
`default_nettype none

package ll_config_pkg;

  // Buffer sizing
  localparam int NUM_QUEUES = 4;
  localparam int LL_DEPTH   = 16;
  localparam int DATA_WIDTH = 4;

  // RAM read latency, and one sub-list per cycle of a refill round trip
  localparam int READ_DELAY = 3;
  localparam int LANES      = READ_DELAY + 2;

  localparam int ADDR_WIDTH = $clog2(LL_DEPTH);
  localparam int CNT_WIDTH  = $clog2(LL_DEPTH + 1);
  localparam int QID_WIDTH  = $clog2(NUM_QUEUES);
  localparam int LANE_WIDTH = $clog2(LANES);

endpackage

`default_nettype wire

/* ll_types_pkg.sv */
`default_nettype none

package ll_types_pkg;

  import ll_config_pkg::*;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [QID_WIDTH-1:0]  qid_t;
  typedef logic [CNT_WIDTH-1:0]  cnt_t;
  typedef logic [LANE_WIDTH-1:0] lane_t;

  typedef enum logic {FL_INIT, FL_RUN} fl_state_t;

  // Round-robin step through the sub-lists
  function automatic lane_t next_lane(lane_t lane);
    return (lane == lane_t'(LANES - 1)) ? '0 : lane + 1'b1;
  endfunction

endpackage

`default_nettype wire

/* pipelined_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module pipelined_ram #(
  parameter int WIDTH = 4,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [WIDTH-1:0]         wr_data,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]         rd_data
);

  import ll_config_pkg::*;

  logic [WIDTH-1:0]         mem [DEPTH];
  logic                     wr_en_q;
  logic [$clog2(DEPTH)-1:0] wr_addr_q;
  logic [WIDTH-1:0]         wr_data_q;
  logic [$clog2(DEPTH)-1:0] rd_addr_q;
  logic [READ_DELAY-2:0]    vld_pipe;
  logic [WIDTH-1:0]         dat_pipe [READ_DELAY-1];

  // Bit 0 is the registered read enable
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en_q  <= 1'b0;
      vld_pipe <= '0;
    end else begin
      wr_en_q  <= wr_en;
      vld_pipe <= {vld_pipe[READ_DELAY-3:0], rd_en};
    end
  end

  // Each stage only loads on a valid read, so the output holds between reads
  always_ff @(posedge clk) begin
    wr_addr_q <= wr_addr;
    wr_data_q <= wr_data;
    rd_addr_q <= rd_addr;
    if (wr_en_q) begin
      mem[wr_addr_q] <= wr_data_q;
    end
    if (vld_pipe[0]) begin
      dat_pipe[0] <= mem[rd_addr_q];
    end
    for (int i = 1; i < READ_DELAY - 1; i++) begin
      if (vld_pipe[i]) begin
        dat_pipe[i] <= dat_pipe[i-1];
      end
    end
  end

  assign rd_data = dat_pipe[READ_DELAY-2];

endmodule

`default_nettype wire

/* enq_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module enq_arbiter (
  input  logic                clk,
  input  logic                reset,
  input  logic                init_done,
  input  logic                enq_vld,
  input  logic                deq_vld,
  input  ll_types_pkg::qid_t  enq_id,
  input  ll_types_pkg::data_t enq_data,
  output logic                eff_enq,
  output ll_types_pkg::qid_t  eff_enq_id,
  output ll_types_pkg::data_t eff_enq_data
);

  import ll_types_pkg::*;

  logic  hold_vld;
  qid_t  hold_id;
  data_t hold_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      hold_vld <= 1'b0;
    end else if (init_done) begin
      hold_vld <= enq_vld && deq_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (enq_vld && deq_vld) begin
      hold_id   <= enq_id;
      hold_data <= enq_data;
    end
  end

  // Held enqueue wins, a lone one goes straight through
  assign eff_enq      = init_done && (hold_vld || (enq_vld && !deq_vld));
  assign eff_enq_id   = hold_vld ? hold_id : enq_id;
  assign eff_enq_data = hold_vld ? hold_data : enq_data;

endmodule

`default_nettype wire

/* free_list.sv */
`timescale 1ns/100ps
`default_nettype none

module free_list (
  input  logic                clk,
  input  logic                reset,
  input  logic                eff_enq,
  input  logic                deq_vld,
  input  ll_types_pkg::addr_t push_addr,
  input  ll_types_pkg::addr_t next_rd_data,
  output logic                init_done,
  output ll_types_pkg::addr_t pop_addr,
  output logic                fl_link_wr,
  output ll_types_pkg::addr_t fl_link_addr,
  output ll_types_pkg::addr_t fl_link_data,
  output logic                fl_next_rd,
  output ll_types_pkg::addr_t fl_next_addr
);

  import ll_config_pkg::*;
  import ll_types_pkg::*;

  fl_state_t               state;
  cnt_t                    fl_cnt;
  cnt_t  [LANES-1:0]       lane_cnt;
  addr_t [LANES-1:0]       head_ptr;
  addr_t [LANES-1:0]       tail_ptr;
  lane_t                   head_lane;
  lane_t                   tail_lane;
  logic  [READ_DELAY-1:0]  rd_vld_sr;
  lane_t [READ_DELAY-1:0]  rd_lane_sr;
  logic                    push_en;
  addr_t                   push_val;
  logic                    tail_empty;

  // Init walk pushes every address in turn, same path as a dequeue
  assign init_done  = (state == FL_RUN);
  assign push_en    = (state == FL_INIT) || deq_vld;
  assign push_val   = (state == FL_INIT) ? addr_t'(fl_cnt) : push_addr;
  assign tail_empty = (lane_cnt[tail_lane] == '0);

  assign pop_addr     = head_ptr[head_lane];
  assign fl_link_wr   = push_en && !tail_empty;
  assign fl_link_addr = tail_ptr[tail_lane];
  assign fl_link_data = push_val;
  assign fl_next_rd   = eff_enq && (lane_cnt[head_lane] > cnt_t'(1));
  assign fl_next_addr = head_ptr[head_lane];

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= FL_INIT;
      fl_cnt    <= '0;
      lane_cnt  <= '0;
      head_lane <= '0;
      tail_lane <= '0;
    end else begin
      if ((state == FL_INIT) && (fl_cnt == cnt_t'(LL_DEPTH - 1))) begin
        state <= FL_RUN;
      end
      if (push_en) begin
        fl_cnt              <= fl_cnt + 1'b1;
        lane_cnt[tail_lane] <= lane_cnt[tail_lane] + 1'b1;
        tail_lane           <= next_lane(tail_lane);
      end else if (eff_enq) begin
        fl_cnt              <= fl_cnt - 1'b1;
        lane_cnt[head_lane] <= lane_cnt[head_lane] - 1'b1;
        head_lane           <= next_lane(head_lane);
      end
    end
  end

  // Tags follow the next-pointer read through the RAM
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld_sr <= '0;
    end else begin
      rd_vld_sr <= {rd_vld_sr[READ_DELAY-2:0], fl_next_rd};
    end
  end

  always_ff @(posedge clk) begin
    rd_lane_sr <= {rd_lane_sr[READ_DELAY-2:0], head_lane};
  end

  always_ff @(posedge clk) begin
    if (push_en) begin
      tail_ptr[tail_lane] <= push_val;
      if (tail_empty) begin
        head_ptr[tail_lane] <= push_val;
      end
    end
    // Refill of a popped lane's head
    if (rd_vld_sr[READ_DELAY-1]) begin
      head_ptr[rd_lane_sr[READ_DELAY-1]] <= next_rd_data;
    end
  end

endmodule

`default_nettype wire

/* queue_table.sv */
`timescale 1ns/100ps
`default_nettype none

module queue_table (
  input  logic                clk,
  input  logic                reset,
  input  logic                init_done,
  input  logic                eff_enq,
  input  ll_types_pkg::qid_t  eff_enq_id,
  input  logic                deq_vld,
  input  ll_types_pkg::qid_t  deq_id,
  input  ll_types_pkg::addr_t pop_addr,
  input  ll_types_pkg::addr_t next_rd_data,
  output ll_types_pkg::addr_t push_addr,
  output logic                q_link_wr,
  output ll_types_pkg::addr_t q_link_addr,
  output ll_types_pkg::addr_t q_link_data,
  output logic                q_next_rd,
  output ll_types_pkg::addr_t q_next_addr,
  output logic                data_rd,
  output ll_types_pkg::addr_t data_rd_addr
);

  import ll_config_pkg::*;
  import ll_types_pkg::*;

  cnt_t  [NUM_QUEUES-1:0][LANES-1:0] lane_cnt;
  addr_t [NUM_QUEUES-1:0][LANES-1:0] head_ptr;
  addr_t [NUM_QUEUES-1:0][LANES-1:0] tail_ptr;
  lane_t [NUM_QUEUES-1:0]            head_lane;
  lane_t [NUM_QUEUES-1:0]            tail_lane;
  logic  [READ_DELAY-1:0]            rd_vld_sr;
  lane_t [READ_DELAY-1:0]            rd_lane_sr;
  qid_t  [READ_DELAY-1:0]            rd_qid_sr;
  lane_t                             enq_lane;
  lane_t                             deq_lane;
  logic                              enq_empty;
  logic                              deq_go;

  assign enq_lane  = tail_lane[eff_enq_id];
  assign deq_lane  = head_lane[deq_id];
  assign enq_empty = (lane_cnt[eff_enq_id][enq_lane] == '0);
  assign deq_go    = init_done && deq_vld;

  // Enqueue links the new entry behind the lane's tail
  assign q_link_wr   = eff_enq && !enq_empty;
  assign q_link_addr = tail_ptr[eff_enq_id][enq_lane];
  assign q_link_data = pop_addr;

  // Dequeue reads and frees the lane's head
  assign push_addr    = head_ptr[deq_id][deq_lane];
  assign q_next_rd    = deq_go && (lane_cnt[deq_id][deq_lane] > cnt_t'(1));
  assign q_next_addr  = push_addr;
  assign data_rd      = deq_go;
  assign data_rd_addr = push_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      lane_cnt  <= '0;
      head_lane <= '0;
      tail_lane <= '0;
    end else if (eff_enq) begin
      lane_cnt[eff_enq_id][enq_lane] <= lane_cnt[eff_enq_id][enq_lane] + 1'b1;
      tail_lane[eff_enq_id]          <= next_lane(enq_lane);
    end else if (deq_go) begin
      lane_cnt[deq_id][deq_lane] <= lane_cnt[deq_id][deq_lane] - 1'b1;
      head_lane[deq_id]          <= next_lane(deq_lane);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld_sr <= '0;
    end else begin
      rd_vld_sr <= {rd_vld_sr[READ_DELAY-2:0], q_next_rd};
    end
  end

  always_ff @(posedge clk) begin
    rd_lane_sr <= {rd_lane_sr[READ_DELAY-2:0], deq_lane};
    rd_qid_sr  <= {rd_qid_sr[READ_DELAY-2:0], deq_id};
  end

  always_ff @(posedge clk) begin
    if (eff_enq) begin
      tail_ptr[eff_enq_id][enq_lane] <= pop_addr;
      if (enq_empty) begin
        head_ptr[eff_enq_id][enq_lane] <= pop_addr;
      end
    end
    // Next pointer of the old head becomes the new head
    if (rd_vld_sr[READ_DELAY-1]) begin
      head_ptr[rd_qid_sr[READ_DELAY-1]][rd_lane_sr[READ_DELAY-1]] <= next_rd_data;
    end
  end

endmodule

`default_nettype wire

/* link_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module link_memory (
  input  logic                clk,
  input  logic                reset,
  input  logic                init_done,
  input  logic                eff_enq,
  input  ll_types_pkg::data_t eff_enq_data,
  input  ll_types_pkg::addr_t pop_addr,
  input  logic                fl_link_wr,
  input  ll_types_pkg::addr_t fl_link_addr,
  input  ll_types_pkg::addr_t fl_link_data,
  input  logic                fl_next_rd,
  input  ll_types_pkg::addr_t fl_next_addr,
  input  logic                q_link_wr,
  input  ll_types_pkg::addr_t q_link_addr,
  input  ll_types_pkg::addr_t q_link_data,
  input  logic                q_next_rd,
  input  ll_types_pkg::addr_t q_next_addr,
  input  logic                data_rd,
  input  ll_types_pkg::addr_t data_rd_addr,
  output ll_types_pkg::addr_t next_rd_data,
  output ll_types_pkg::data_t deq_data
);

  import ll_config_pkg::*;
  import ll_types_pkg::*;

  logic  q_owns_wr;
  logic  ptr_wr_en;
  addr_t ptr_wr_addr;
  addr_t ptr_wr_data;
  logic  ptr_rd_en;
  addr_t ptr_rd_addr;

  // Free list writes while initialising or on dequeue, the queue on enqueue
  assign q_owns_wr   = init_done && eff_enq;
  assign ptr_wr_en   = q_owns_wr ? q_link_wr : fl_link_wr;
  assign ptr_wr_addr = q_owns_wr ? q_link_addr : fl_link_addr;
  assign ptr_wr_data = q_owns_wr ? q_link_data : fl_link_data;

  // Enqueue pops the free list, dequeue pops a queue
  assign ptr_rd_en   = eff_enq ? fl_next_rd : q_next_rd;
  assign ptr_rd_addr = eff_enq ? fl_next_addr : q_next_addr;

  pipelined_ram #(.WIDTH(ADDR_WIDTH), .DEPTH(LL_DEPTH)) next_ptr_ram (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (ptr_wr_en),
    .wr_addr (ptr_wr_addr),
    .wr_data (ptr_wr_data),
    .rd_en   (ptr_rd_en),
    .rd_addr (ptr_rd_addr),
    .rd_data (next_rd_data)
  );

  pipelined_ram #(.WIDTH(DATA_WIDTH), .DEPTH(LL_DEPTH)) data_ram (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (eff_enq),
    .wr_addr (pop_addr),
    .wr_data (eff_enq_data),
    .rd_en   (data_rd),
    .rd_addr (data_rd_addr),
    .rd_data (deq_data)
  );

endmodule

`default_nettype wire

/* ll_queue_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ll_queue_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                enq_vld,
  input  ll_types_pkg::qid_t  enq_id,
  input  ll_types_pkg::data_t enq_data,
  input  logic                deq_vld,
  input  ll_types_pkg::qid_t  deq_id,
  output ll_types_pkg::data_t deq_data,
  output logic                init_done
);

  import ll_types_pkg::*;

  logic  eff_enq;
  qid_t  eff_enq_id;
  data_t eff_enq_data;
  addr_t pop_addr;
  addr_t push_addr;
  addr_t next_rd_data;
  logic  fl_link_wr;
  addr_t fl_link_addr;
  addr_t fl_link_data;
  logic  fl_next_rd;
  addr_t fl_next_addr;
  logic  q_link_wr;
  addr_t q_link_addr;
  addr_t q_link_data;
  logic  q_next_rd;
  addr_t q_next_addr;
  logic  data_rd;
  addr_t data_rd_addr;

  enq_arbiter enq_arbiter_inst (
    .clk          (clk),
    .reset        (reset),
    .init_done    (init_done),
    .enq_vld      (enq_vld),
    .deq_vld      (deq_vld),
    .enq_id       (enq_id),
    .enq_data     (enq_data),
    .eff_enq      (eff_enq),
    .eff_enq_id   (eff_enq_id),
    .eff_enq_data (eff_enq_data)
  );

  free_list free_list_inst (
    .clk          (clk),
    .reset        (reset),
    .eff_enq      (eff_enq),
    .deq_vld      (deq_vld),
    .push_addr    (push_addr),
    .next_rd_data (next_rd_data),
    .init_done    (init_done),
    .pop_addr     (pop_addr),
    .fl_link_wr   (fl_link_wr),
    .fl_link_addr (fl_link_addr),
    .fl_link_data (fl_link_data),
    .fl_next_rd   (fl_next_rd),
    .fl_next_addr (fl_next_addr)
  );

  queue_table queue_table_inst (
    .clk          (clk),
    .reset        (reset),
    .init_done    (init_done),
    .eff_enq      (eff_enq),
    .eff_enq_id   (eff_enq_id),
    .deq_vld      (deq_vld),
    .deq_id       (deq_id),
    .pop_addr     (pop_addr),
    .next_rd_data (next_rd_data),
    .push_addr    (push_addr),
    .q_link_wr    (q_link_wr),
    .q_link_addr  (q_link_addr),
    .q_link_data  (q_link_data),
    .q_next_rd    (q_next_rd),
    .q_next_addr  (q_next_addr),
    .data_rd      (data_rd),
    .data_rd_addr (data_rd_addr)
  );

  link_memory link_memory_inst (
    .clk          (clk),
    .reset        (reset),
    .init_done    (init_done),
    .eff_enq      (eff_enq),
    .eff_enq_data (eff_enq_data),
    .pop_addr     (pop_addr),
    .fl_link_wr   (fl_link_wr),
    .fl_link_addr (fl_link_addr),
    .fl_link_data (fl_link_data),
    .fl_next_rd   (fl_next_rd),
    .fl_next_addr (fl_next_addr),
    .q_link_wr    (q_link_wr),
    .q_link_addr  (q_link_addr),
    .q_link_data  (q_link_data),
    .q_next_rd    (q_next_rd),
    .q_next_addr  (q_next_addr),
    .data_rd      (data_rd),
    .data_rd_addr (data_rd_addr),
    .next_rd_data (next_rd_data),
    .deq_data     (deq_data)
  );

endmodule

`default_nettype wire

/* ll_queue_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module ll_queue_properties (
  input logic                clk,
  input logic                reset,
  input logic                init_done,
  input logic                eff_enq,
  input logic                deq_vld,
  input ll_types_pkg::qid_t  deq_id,
  input ll_types_pkg::cnt_t  fl_cnt,
  input ll_types_pkg::cnt_t [ll_config_pkg::NUM_QUEUES-1:0][ll_config_pkg::LANES-1:0] q_lane_cnt
);

  import ll_config_pkg::*;
  import ll_types_pkg::*;

  int deq_level;
  int fail_count = 0;

  // Entries held by the dequeued queue over all its lanes
  always_comb begin
    deq_level = 0;
    for (int i = 0; i < LANES; i++) begin
      deq_level += int'(q_lane_cnt[deq_id][i]);
    end
  end

  no_back_to_back_enq: assert property (@(posedge clk) disable iff (reset || !init_done)
    eff_enq |=> !eff_enq)
    else begin
      fail_count++;
      $error("eff_enq high on two consecutive cycles");
    end

  no_back_to_back_deq: assert property (@(posedge clk) disable iff (reset || !init_done)
    deq_vld |=> !deq_vld)
    else begin
      fail_count++;
      $error("deq_vld high on two consecutive cycles");
    end

  enq_deq_exclusive: assert property (@(posedge clk) disable iff (reset || !init_done)
    !(eff_enq && deq_vld))
    else begin
      fail_count++;
      $error("eff_enq and deq_vld high in the same cycle");
    end

  enq_not_full: assert property (@(posedge clk) disable iff (reset || !init_done)
    eff_enq |-> (fl_cnt != '0))
    else begin
      fail_count++;
      $error("enqueue while the free list is empty");
    end

  deq_not_empty: assert property (@(posedge clk) disable iff (reset || !init_done)
    deq_vld |-> (deq_level != 0))
    else begin
      fail_count++;
      $error("dequeue from empty queue %0d", deq_id);
    end

endmodule

bind ll_queue_top ll_queue_properties ll_queue_properties_inst (
  .clk        (clk),
  .reset      (reset),
  .init_done  (init_done),
  .eff_enq    (eff_enq),
  .deq_vld    (deq_vld),
  .deq_id     (deq_id),
  .fl_cnt     (free_list_inst.fl_cnt),
  .q_lane_cnt (queue_table_inst.lane_cnt)
);

`default_nettype wire

/* ll_queue_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ll_queue_tb;

  import ll_config_pkg::*;
  import ll_types_pkg::*;

  localparam int MAX_WORDS = 512;
  localparam int FIELDS    = 5;

  logic  clk;
  logic  reset;
  logic  enq_vld;
  qid_t  enq_id;
  data_t enq_data;
  logic  deq_vld;
  qid_t  deq_id;
  data_t deq_data;
  logic  init_done;

  logic [3:0] test_mem [MAX_WORDS];
  int         num_tests;
  int         num_ops;
  int         cycle_limit;
  int         errors;
  int         failed_tests;

  ll_queue_top ll_queue_top_inst (
    .clk       (clk),
    .reset     (reset),
    .enq_vld   (enq_vld),
    .enq_id    (enq_id),
    .enq_data  (enq_data),
    .deq_vld   (deq_vld),
    .deq_id    (deq_id),
    .deq_data  (deq_data),
    .init_done (init_done)
  );

  always #50 clk = ~clk;

  task automatic check_data(input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Error: deq_data = 0x%h, expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_init(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: init_done = 0x%h, expected 0x%h", got, exp);
      errors++;
    end
  endtask

  function automatic int error_total();
    return errors + ll_queue_top_inst.ll_queue_properties_inst.fail_count;
  endfunction

  // Inputs change 10 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic idle_gap();
    int extra;
    extra = int'($urandom % 3);
    repeat (1 + extra) step();
  endtask

  task automatic enqueue_item(input qid_t q, input data_t d);
    enq_vld  = 1'b1;
    enq_id   = q;
    enq_data = d;
    step();
    enq_vld  = 1'b0;
    idle_gap();
  endtask

  // Read data is stable READ_DELAY edges after the sampling edge
  task automatic dequeue_and_check(input qid_t q, input data_t exp);
    deq_vld = 1'b1;
    deq_id  = q;
    step();
    deq_vld = 1'b0;
    repeat (READ_DELAY) step();
    check_data(deq_data, exp);
    idle_gap();
  endtask

  task automatic collide_and_check(input qid_t eq, input data_t ed, input qid_t dq,
                                   input data_t exp);
    enq_vld  = 1'b1;
    enq_id   = eq;
    enq_data = ed;
    deq_vld  = 1'b1;
    deq_id   = dq;
    step();
    enq_vld  = 1'b0;
    deq_vld  = 1'b0;
    repeat (READ_DELAY) step();
    check_data(deq_data, exp);
    idle_gap();
  endtask

  function automatic string op_name(input logic [3:0] op);
    case (op)
      4'h0: return "idle";
      4'h1: return "enqueue";
      4'h2: return "dequeue";
      4'h3: return "collide";
      4'h4: return "enqueue burst";
      4'h5: return "dequeue burst";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_test(input int idx, input string what, input int errs_before);
    if (error_total() == errs_before) begin
      $display("test %0d %s: ok", idx, what);
    end else begin
      $display("test %0d %s: mismatch", idx, what);
      failed_tests++;
    end
  endtask

  initial begin
    int         pos;
    int         errs_before;
    logic [3:0] op;
    logic [3:0] a;
    logic [3:0] b;
    logic [3:0] c;
    logic [3:0] d;
    clk          = 1'b0;
    reset        = 1'b1;
    enq_vld      = 1'b0;
    enq_id       = '0;
    enq_data     = '0;
    deq_vld      = 1'b0;
    deq_id       = '0;
    errors       = 0;
    failed_tests = 0;
    void'($urandom(32'h67c));

    // Unused words read as the end marker
    for (int i = 0; i < MAX_WORDS; i++) begin
      test_mem[i] = 4'hf;
    end
    $readmemh("ll_queue_tests.txt", test_mem);
    num_tests = 0;
    num_ops   = 0;
    pos       = 0;
    while ((pos + FIELDS <= MAX_WORDS) && (test_mem[pos] != 4'hf)) begin
      num_tests++;
      if ((test_mem[pos] == 4'h4) || (test_mem[pos] == 4'h5)) begin
        num_ops += int'(test_mem[pos+3]);
      end else begin
        num_ops++;
      end
      pos += FIELDS;
    end
    cycle_limit = 3 + LL_DEPTH + 4 + num_ops * (READ_DELAY + 6);

    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;
    errs_before = error_total();
    check_init(init_done, 1'b0);
    for (int i = 1; i <= LL_DEPTH; i++) begin
      step();
      check_init(init_done, i == LL_DEPTH);
    end
    report_test(0, "init", errs_before);

    pos = 0;
    for (int t = 0; t < num_tests; t++) begin
      op = test_mem[pos];
      a  = test_mem[pos+1];
      b  = test_mem[pos+2];
      c  = test_mem[pos+3];
      d  = test_mem[pos+4];
      errs_before = error_total();
      case (op)
        4'h0: idle_gap();
        4'h1: enqueue_item(qid_t'(a), data_t'(b));
        4'h2: dequeue_and_check(qid_t'(a), data_t'(b));
        4'h3: collide_and_check(qid_t'(a), data_t'(b), qid_t'(c), data_t'(d));
        4'h4: begin
          for (int k = 0; k < int'(c); k++) begin
            enqueue_item(qid_t'(a), data_t'(b + k));
          end
        end
        4'h5: begin
          for (int k = 0; k < int'(c); k++) begin
            dequeue_and_check(qid_t'(a), data_t'(b + k));
          end
        end
        default: begin
          $display("Unknown operation code %h on test line %0d", op, t + 1);
          errors++;
        end
      endcase
      report_test(t + 1, op_name(op), errs_before);
      pos += FIELDS;
    end

    $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
             num_tests + 1, failed_tests, error_total());
    if (error_total() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Limit set from the number of operations in the test file
  initial begin
    #1;
    repeat (cycle_limit) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not finish", cycle_limit);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
ll_config_pkg.sv
ll_types_pkg.sv
pipelined_ram.sv
enq_arbiter.sv
free_list.sv
queue_table.sv
link_memory.sv
ll_queue_top.sv
ll_queue_properties.sv
ll_queue_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = ll_queue_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ll_queue_tests.txt */
// Columns (hex): op a b c d. op 0 idle, 1 enqueue a=queue b=data, 2 dequeue a=queue b=expected,
// 3 collide a=queue b=data with c=queue d=expected, 4/5 burst a=queue b=first c=count, f end
1 0 3 0 0
1 0 7 0 0
2 0 3 0 0
2 0 7 0 0
1 1 1 0 0
1 2 2 0 0
1 3 3 0 0
1 0 4 0 0
2 3 3 0 0
1 1 5 0 0
2 1 1 0 0
2 0 4 0 0
2 2 2 0 0
2 1 5 0 0
1 2 c 0 0
1 2 d 0 0
3 2 e 2 c
2 2 d 0 0
2 2 e 0 0
0 0 0 0 0
4 2 0 c 0
4 1 c 4 0
5 2 0 c 0
5 1 c 4 0
4 3 1 f 0
4 0 5 1 0
5 3 1 f 0
5 0 5 1 0
f 0 0 0 0
